//--- touch_pkg.sv
package touch_pkg;

	// Converter result width
	localparam int adc_w = 12;

	// Channel select codes, placed as-is into bits 2:1 of the command byte
	typedef enum logic [1:0] {
		chan_y = 2'b00,
		chan_z = 2'b01,
		chan_x = 2'b10
	} touch_chan_e;

	// Fixed bits of the command byte
	localparam logic cmd_start_bit = 1'b1; // Bit 0, marks start of command
	localparam logic cmd_ref_bit = 1'b1;   // Bit 3, reference select

	// One kept conversion per channel group
	typedef struct packed {
		logic valid;              // One-cycle pulse
		touch_chan_e chan;        // Channel this value belongs to
		logic [adc_w-1:0] value;  // Raw result
	} touch_sample_t;

	// Scaled coordinate pair
	typedef struct packed {
		logic valid;          // Pulses when either half updates
		logic [adc_w-1:0] x;  // X minus window minimum
		logic [adc_w-1:0] y;  // Y minus window minimum
	} coord_t;

	// Press decision with raw pressure
	typedef struct packed {
		logic valid;
		logic pressed;        // Z strictly above threshold
		logic [adc_w-1:0] z;
	} press_t;

	// Calibration settings from the host
	typedef struct packed {
		logic [adc_w-1:0] x_min;
		logic [adc_w-1:0] x_max;
		logic [adc_w-1:0] y_min;
		logic [adc_w-1:0] y_max;
		logic [adc_w-1:0] z_thresh;
	} cal_t;

endpackage

//--- wb_pkg.sv
package wb_pkg;

	localparam int wb_adr_w = 4;  // Word address width
	localparam int wb_dat_w = 32;
	localparam int wb_sel_w = wb_dat_w / 8;

	// Master to slave, held stable until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wb_adr_w-1:0] adr;  // Word address
		logic [wb_dat_w-1:0] dat;  // Write data
		logic [wb_sel_w-1:0] sel;  // Byte lanes
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic ack;
		logic [wb_dat_w-1:0] dat;  // Read data, valid with ack
	} wb_rsp_t;

	// Register map
	localparam logic [wb_adr_w-1:0] reg_status = 4'd0;    // RO, pressed and frame count
	localparam logic [wb_adr_w-1:0] reg_x = 4'd1;         // RO, scaled X
	localparam logic [wb_adr_w-1:0] reg_y = 4'd2;         // RO, scaled Y
	localparam logic [wb_adr_w-1:0] reg_z = 4'd3;         // RO, raw Z
	localparam logic [wb_adr_w-1:0] reg_x_min = 4'd4;     // RW
	localparam logic [wb_adr_w-1:0] reg_x_max = 4'd5;     // RW
	localparam logic [wb_adr_w-1:0] reg_y_min = 4'd6;     // RW
	localparam logic [wb_adr_w-1:0] reg_y_max = 4'd7;     // RW
	localparam logic [wb_adr_w-1:0] reg_z_thresh = 4'd8;  // RW

endpackage

//--- touch_spi_engine.sv
`timescale 1ns/10ps

module touch_spi_engine #(
	parameter int clk_div = 4,  // cclk cycles per touch_clk half period
	parameter int reps = 3      // Conversions per channel
) (
	input logic cclk,
	input logic rstb,
	input logic data_in,     // Result bits from the converter
	input logic touch_busy,  // Not used, result timing is fixed
	output logic touch_clk,
	output logic touch_csb,
	output logic data_out,   // Command bits to the converter
	output touch_pkg::touch_sample_t sample
);
	import touch_pkg::*;

	localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;
	localparam int rep_w = (reps > 1) ? $clog2(reps) : 1;

	// Steps of one transaction, counted in falling edges
	localparam logic [4:0] step_gap = 5'd8;    // Conversion gap
	localparam logic [4:0] step_rx_lo = 5'd9;  // First result bit
	localparam logic [4:0] step_rx_hi = 5'd20; // Last result bit
	localparam logic [4:0] step_idle = 5'd21;  // Chip select released
	localparam logic [4:0] step_last = 5'd24;

	localparam logic [7:0] cmd_mask_init = 8'h01;  // LSB of command goes first
	localparam logic [adc_w-1:0] res_mask_init = {1'b1, {(adc_w-1){1'b0}}};  // MSB first

	logic [div_w-1:0] div_cnt;
	logic div_tick;   // Half period done
	logic fall_tick;  // This cycle makes a falling edge
	logic [4:0] step;
	logic sending;
	logic receiving;
	logic txn_end;
	logic last_rep;
	logic [7:0] cmd_byte;
	logic [7:0] cmd_mask;      // One-hot, walks up the command byte
	logic [adc_w-1:0] res_mask; // One-hot, walks down the result
	logic [adc_w-1:0] res_q;    // Result being assembled
	logic [rep_w-1:0] rep_cnt;
	touch_chan_e chan_q;

	// X -> Y -> Z -> X
	function automatic touch_chan_e next_chan(input touch_chan_e c);
		touch_chan_e n;
		case (c)
			chan_x: n = chan_y;
			chan_y: n = chan_z;
			default: n = chan_x;
		endcase
		return n;
	endfunction

	assign div_tick = (div_cnt == div_w'(clk_div - 1));
	assign fall_tick = div_tick & touch_clk;  // Clock high now, toggles low

	assign sending = (step < step_gap);
	assign receiving = (step >= step_rx_lo) && (step <= step_rx_hi);
	assign txn_end = (step == step_last);
	assign last_rep = (rep_cnt == rep_w'(reps - 1));

	// Start bit, channel code, reference bit, upper nibble zero
	assign cmd_byte = {4'b0000, cmd_ref_bit, chan_q, cmd_start_bit};

	// Serial clock divider
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			div_cnt <= '0;
			touch_clk <= 1'b0;
		end else if (div_tick) begin
			div_cnt <= '0;
			touch_clk <= ~touch_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Shifting and sequencing, all on falling edges of touch_clk
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			step <= '0;
			cmd_mask <= cmd_mask_init;
			res_mask <= res_mask_init;
			touch_csb <= 1'b1;
			data_out <= 1'b0;
			rep_cnt <= '0;
			chan_q <= chan_x;  // First group is X
			sample <= '0;
		end else begin
			sample.valid <= 1'b0;  // Pulse only
			if (fall_tick) begin
				if (sending) begin
					touch_csb <= 1'b0;
					data_out <= |(cmd_byte & cmd_mask);
					cmd_mask <= cmd_mask << 1;
				end else begin
					data_out <= 1'b0;  // Quiet line outside the command
				end

				if (step == step_gap)
					res_q <= '0;  // Fresh result each transaction
				if (receiving) begin
					if (data_in)
						res_q <= res_q | res_mask;
					res_mask <= res_mask >> 1;
				end

				if (step == step_idle)
					touch_csb <= 1'b1;

				if (txn_end) begin
					step <= '0;
					cmd_mask <= cmd_mask_init;
					res_mask <= res_mask_init;
					if (last_rep) begin
						// Keep only the last conversion of the group
						rep_cnt <= '0;
						sample.valid <= 1'b1;
						sample.chan <= chan_q;
						sample.value <= res_q;
						chan_q <= next_chan(chan_q);
					end else begin
						rep_cnt <= rep_cnt + 1'b1;
					end
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

endmodule

//--- coord_scaler.sv
`timescale 1ns/10ps

module coord_scaler (
	input logic cclk,
	input logic rstb,
	input touch_pkg::touch_sample_t sample,
	input touch_pkg::cal_t cal,
	output touch_pkg::coord_t coord
);
	import touch_pkg::*;

	logic is_x;  // Current sample is an X result
	logic is_y;
	logic [adc_w-1:0] x_scaled;
	logic [adc_w-1:0] y_scaled;

	// Clamp into [lo, hi] and move the window down to zero
	function automatic logic [adc_w-1:0] window(
		input logic [adc_w-1:0] v,
		input logic [adc_w-1:0] lo,
		input logic [adc_w-1:0] hi
	);
		logic [adc_w-1:0] c;
		if (v < lo)
			c = lo;
		else if (v > hi)
			c = hi;
		else
			c = v;
		return c - lo;
	endfunction

	assign is_x = sample.valid && (sample.chan == chan_x);
	assign is_y = sample.valid && (sample.chan == chan_y);

	assign x_scaled = window(sample.value, cal.x_min, cal.x_max);
	assign y_scaled = window(sample.value, cal.y_min, cal.y_max);

	// Each half of the pair updates on its own channel
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			coord <= '0;
		end else begin
			coord.valid <= is_x | is_y;  // Z samples pass by
			if (is_x)
				coord.x <= x_scaled;
			if (is_y)
				coord.y <= y_scaled;
		end
	end

endmodule

//--- press_detector.sv
`timescale 1ns/10ps

module press_detector (
	input logic cclk,
	input logic rstb,
	input touch_pkg::touch_sample_t sample,
	input touch_pkg::cal_t cal,
	output touch_pkg::press_t press
);
	import touch_pkg::*;

	logic is_z;   // Current sample is a Z result
	logic above;  // Strictly over threshold, equal counts as released

	assign is_z = sample.valid && (sample.chan == chan_z);
	assign above = (sample.value > cal.z_thresh);

	// Decision holds between Z samples
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			press <= '0;
		end else begin
			press.valid <= is_z;
			if (is_z) begin
				press.pressed <= above;
				press.z <= sample.value;  // Raw pressure travels with the flag
			end
		end
	end

endmodule

//--- touch_wb_regs.sv
`timescale 1ns/10ps

module touch_wb_regs #(
	parameter touch_pkg::cal_t cal_reset = '0  // Calibration after reset
) (
	input logic cclk,
	input logic rstb,
	input wb_pkg::wb_req_t wb_req,
	output wb_pkg::wb_rsp_t wb_rsp,
	input touch_pkg::coord_t coord,
	input touch_pkg::press_t press,
	output touch_pkg::cal_t cal,
	output logic touch_irq
);
	import wb_pkg::*;
	import touch_pkg::*;

	logic access;  // Transfer seen and not yet acknowledged
	logic wr_en;
	cal_t cal_q;
	logic [adc_w-1:0] x_q;
	logic [adc_w-1:0] y_q;
	logic [adc_w-1:0] z_q;
	logic pressed_q;
	logic [15:0] frame_cnt;  // Wraps
	logic [wb_dat_w-1:0] rd_data;

	// Byte-lane merge into a 12-bit register, lanes 2 and 3 hold nothing
	function automatic logic [adc_w-1:0] lane_write(
		input logic [adc_w-1:0] old,
		input logic [wb_dat_w-1:0] dat,
		input logic [wb_sel_w-1:0] sel
	);
		logic [adc_w-1:0] v;
		v = old;
		if (sel[0])
			v[7:0] = dat[7:0];
		if (sel[1])
			v[adc_w-1:8] = dat[adc_w-1:8];
		return v;
	endfunction

	// Ack never twice in a row, so a held request is taken once
	assign access = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
	assign wr_en = access & wb_req.we;

	assign cal = cal_q;
	assign touch_irq = pressed_q;  // Level, follows latched press

	// Read mux, unmapped words give zero
	always_comb begin
		case (wb_req.adr)
			reg_status: rd_data = {8'h00, frame_cnt, 7'h00, pressed_q};
			reg_x: rd_data = wb_dat_w'(x_q);
			reg_y: rd_data = wb_dat_w'(y_q);
			reg_z: rd_data = wb_dat_w'(z_q);
			reg_x_min: rd_data = wb_dat_w'(cal_q.x_min);
			reg_x_max: rd_data = wb_dat_w'(cal_q.x_max);
			reg_y_min: rd_data = wb_dat_w'(cal_q.y_min);
			reg_y_max: rd_data = wb_dat_w'(cal_q.y_max);
			reg_z_thresh: rd_data = wb_dat_w'(cal_q.z_thresh);
			default: rd_data = '0;
		endcase
	end

	// One-cycle classic ack with read data
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			wb_rsp.ack <= 1'b0;
		end else begin
			wb_rsp.ack <= access;
			if (access)
				wb_rsp.dat <= rd_data;
		end
	end

	// Calibration writes land as ack rises
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			cal_q <= cal_reset;
		end else if (wr_en) begin
			case (wb_req.adr)
				reg_x_min: cal_q.x_min <= lane_write(cal_q.x_min, wb_req.dat, wb_req.sel);
				reg_x_max: cal_q.x_max <= lane_write(cal_q.x_max, wb_req.dat, wb_req.sel);
				reg_y_min: cal_q.y_min <= lane_write(cal_q.y_min, wb_req.dat, wb_req.sel);
				reg_y_max: cal_q.y_max <= lane_write(cal_q.y_max, wb_req.dat, wb_req.sel);
				reg_z_thresh: begin
					cal_q.z_thresh <= lane_write(cal_q.z_thresh, wb_req.dat, wb_req.sel);
				end
				default: ;  // Read-only and unmapped words ignore writes
			endcase
		end
	end

	// Latched results
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			x_q <= '0;
			y_q <= '0;
			z_q <= '0;
			pressed_q <= 1'b0;
			frame_cnt <= '0;
		end else begin
			if (coord.valid) begin
				x_q <= coord.x;
				y_q <= coord.y;
			end
			if (press.valid) begin
				z_q <= press.z;
				pressed_q <= press.pressed;
				frame_cnt <= frame_cnt + 1'b1;  // Z closes each frame
			end
		end
	end

endmodule

//--- touch_subsystem.sv
`timescale 1ns/10ps

module touch_subsystem #(
	parameter int clk_div = 4,
	parameter int reps = 3,
	parameter touch_pkg::cal_t cal_reset = '{
		x_min: 12'h090,
		x_max: 12'h745,
		y_min: 12'h060,
		y_max: 12'h6f0,
		z_thresh: 12'h100
	}
) (
	input logic cclk,
	input logic rstb,
	input wb_pkg::wb_req_t wb_req,   // Host bus
	output wb_pkg::wb_rsp_t wb_rsp,
	input logic touch_busy,          // Converter busy pin
	input logic data_in,             // Converter serial result
	output logic touch_clk,
	output logic touch_csb,
	output logic data_out,           // Converter serial command
	output logic touch_irq
);
	import touch_pkg::*;

	touch_sample_t sample;  // Kept conversion per channel
	coord_t coord;          // Scaled X/Y pair
	press_t press;          // Press decision and raw Z
	cal_t cal;              // Host calibration

	touch_spi_engine #(
		.clk_div(clk_div),
		.reps(reps)
	) u_engine (
		.cclk(cclk),
		.rstb(rstb),
		.data_in(data_in),
		.touch_busy(touch_busy),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.sample(sample)
	);

	coord_scaler u_scaler (
		.cclk(cclk),
		.rstb(rstb),
		.sample(sample),
		.cal(cal),
		.coord(coord)
	);

	press_detector u_press (
		.cclk(cclk),
		.rstb(rstb),
		.sample(sample),
		.cal(cal),
		.press(press)
	);

	touch_wb_regs #(
		.cal_reset(cal_reset)
	) u_regs (
		.cclk(cclk),
		.rstb(rstb),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.coord(coord),
		.press(press),
		.cal(cal),
		.touch_irq(touch_irq)
	);

endmodule

//--- touch_panel_model.sv
`timescale 1ns/10ps

module touch_panel_model (
	input logic touch_clk,
	input logic touch_csb,
	input logic data_out,     // Command bits from the engine
	output logic data_in,     // Result bits to the engine
	output logic touch_busy
);
	import touch_pkg::*;

	logic [adc_w-1:0] x_val;  // Per-channel results, set by the test
	logic [adc_w-1:0] y_val;
	logic [adc_w-1:0] z_val;
	int cmd_errs;             // Malformed command bytes seen
	int bit_cnt;              // Rising edges since chip select fell
	logic [7:0] cmd;          // Command byte, LSB arrives first
	logic [adc_w-1:0] shift;  // Result on its way out, MSB first

	// Result for a decoded channel code
	function automatic logic [adc_w-1:0] chan_value(input logic [1:0] code);
		logic [adc_w-1:0] v;
		case (code)
			chan_x: v = x_val;
			chan_y: v = y_val;
			chan_z: v = z_val;
			default: v = '0;  // Unused code
		endcase
		return v;
	endfunction

	initial begin
		data_in = 1'b0;
		x_val = '0;
		y_val = '0;
		z_val = '0;
		cmd_errs = 0;
		bit_cnt = 0;
		cmd = '0;
		shift = '0;
	end

	assign touch_busy = 1'b0;  // Conversion time is fixed

	// Command sampled and result launched on rising edges
	always @(posedge touch_clk) begin
		if (touch_csb) begin
			bit_cnt = 0;  // Between transactions
			data_in <= #1 1'b0;
		end else begin
			if (bit_cnt < 8)
				cmd[bit_cnt] = data_out;
			if (bit_cnt == 8) begin
				// Whole byte is in, check the fixed fields
				if (cmd[0] !== cmd_start_bit || cmd[3] !== cmd_ref_bit)
					cmd_errs++;
				if (cmd[7:4] !== 4'h0 || cmd[2:1] === 2'b11)
					cmd_errs++;
				shift = chan_value(cmd[2:1]);
			end
			if (bit_cnt >= 8 && bit_cnt < 8 + adc_w) begin
				data_in <= #1 shift[adc_w-1];  // Engine takes it on the next fall
				shift = shift << 1;
			end else begin
				data_in <= #1 1'b0;
			end
			bit_cnt++;
		end
	end

endmodule

//--- tb_touch_subsystem.sv
`timescale 1ns/10ps

module tb_touch_subsystem;
	import touch_pkg::*;
	import wb_pkg::*;

	localparam int ack_limit = 16;     // Cycles allowed for one ack
	localparam int poll_limit = 1500;  // Status reads allowed per frame
	localparam cal_t default_cal = '{
		x_min: 12'h090,
		x_max: 12'h745,
		y_min: 12'h060,
		y_max: 12'h6f0,
		z_thresh: 12'h100
	};

	logic cclk;
	logic rstb;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic touch_busy;
	logic data_in;
	logic touch_clk;
	logic touch_csb;
	logic data_out;
	logic touch_irq;

	cal_t cal_exp;       // Calibration the DUT should hold
	logic [31:0] lfsr;
	int pass_cnt;
	int fail_cnt;
	int test_base;       // fail_cnt when the current test began

	touch_subsystem #(
		.clk_div(4),
		.reps(3)
	) dut (
		.cclk(cclk),
		.rstb(rstb),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.touch_irq(touch_irq)
	);

	touch_panel_model panel (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.data_in(data_in),
		.touch_busy(touch_busy)
	);

	always #4 cclk = ~cclk;  // 8 ns period

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) pass_cnt++;
		else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			fail_cnt++;
		end
	endtask

	task automatic end_run();
		$display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic timed_out(input string what);
		$display("Timeout: %s never happened", what);
		fail_cnt++;
		end_run();
	endtask

	// Galois step with taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	task automatic draw(output logic [adc_w-1:0] v);
		v = '0;
		for (int i = 0; i < adc_w; i++) begin
			lfsr = lfsr_next(lfsr);  // One step per bit
			v = {v[adc_w-2:0], lfsr[0]};
		end
	endtask

	// Clamp to the window and move it down to zero
	function automatic logic [31:0] scaled(input logic [11:0] v, input logic [11:0] lo,
		input logic [11:0] hi);
		if (v <= lo)
			return 32'h0;
		if (v >= hi)
			return 32'(hi - lo);
		return 32'(v - lo);
	endfunction

	// Single classic transfer with the request held until ack
	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat);
		int n;
		@(posedge cclk);
		#1;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
		n = 0;
		do begin
			@(posedge cclk);
			#1;
			n++;
		end while (!wb_rsp.ack && n < ack_limit);
		wb_req = '0;
		if (!wb_rsp.ack) begin
			timed_out("Wishbone ack");
		end else begin
			check("ack latency", n, 1);  // Ack in the cycle after the request
			rdat = wb_rsp.dat;
		end
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, sel, unused);
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		wb_access(1'b0, adr, 32'h0, 4'hf, dat);
	endtask

	task automatic write_cal(input cal_t c);
		wb_write(reg_x_min, 32'(c.x_min), 4'hf);
		wb_write(reg_x_max, 32'(c.x_max), 4'hf);
		wb_write(reg_y_min, 32'(c.y_min), 4'hf);
		wb_write(reg_y_max, 32'(c.y_max), 4'hf);
		wb_write(reg_z_thresh, 32'(c.z_thresh), 4'hf);
		cal_exp = c;
	endtask

	task automatic check_cal();
		logic [31:0] d;
		wb_read(reg_x_min, d);
		check("reg_x_min", d, 32'(cal_exp.x_min));
		wb_read(reg_x_max, d);
		check("reg_x_max", d, 32'(cal_exp.x_max));
		wb_read(reg_y_min, d);
		check("reg_y_min", d, 32'(cal_exp.y_min));
		wb_read(reg_y_max, d);
		check("reg_y_max", d, 32'(cal_exp.y_max));
		wb_read(reg_z_thresh, d);
		check("reg_z_thresh", d, 32'(cal_exp.z_thresh));
	endtask

	// Poll status until the frame count has risen by n
	task automatic wait_frames(input int n, output logic [15:0] fc);
		logic [31:0] st;
		logic [15:0] start;
		int polls;
		wb_read(reg_status, st);
		start = st[23:8];
		polls = 0;
		do begin
			wb_read(reg_status, st);
			polls++;
		end while (16'(st[23:8] - start) < n && polls < n * poll_limit);
		if (16'(st[23:8] - start) < n)
			timed_out("frame count rise");
		else
			fc = st[23:8];
	endtask

	// Two frames make sure one whole frame used the new values
	task automatic check_frame(input logic [11:0] x, input logic [11:0] y,
		input logic [11:0] z, output logic [15:0] fc);
		logic [31:0] d;
		logic pressed;
		panel.x_val = x;
		panel.y_val = y;
		panel.z_val = z;
		wait_frames(2, fc);
		pressed = (z > cal_exp.z_thresh);
		wb_read(reg_x, d);
		check("reg_x", d, scaled(x, cal_exp.x_min, cal_exp.x_max));
		wb_read(reg_y, d);
		check("reg_y", d, scaled(y, cal_exp.y_min, cal_exp.y_max));
		wb_read(reg_z, d);
		check("reg_z", d, 32'(z));
		wb_read(reg_status, d);
		check("status pressed", d[0], pressed);
		check("touch_irq", touch_irq, pressed);
	endtask

	task automatic test_done(input string name);
		$display("Test %s finished with %0d errors", name, fail_cnt - test_base);
		test_base = fail_cnt;
	endtask

	initial begin
		logic [31:0] d;
		logic [11:0] rx;
		logic [11:0] ry;
		logic [11:0] rz;
		logic [15:0] fc;
		logic [15:0] prev;
		cclk = 1'b0;
		rstb = 1'b0;
		wb_req = '0;
		lfsr = 32'h4d84;
		pass_cnt = 0;
		fail_cnt = 0;
		test_base = 0;
		cal_exp = default_cal;

		// 1 Reset state
		repeat (5) @(posedge cclk);
		#1;
		check("touch_csb in reset", touch_csb, 1'b1);
		check("touch_clk in reset", touch_clk, 1'b0);
		check("data_out in reset", data_out, 1'b0);
		check("touch_irq in reset", touch_irq, 1'b0);
		check("ack in reset", wb_rsp.ack, 1'b0);
		repeat (5) @(posedge cclk);
		#1;
		rstb = 1'b1;
		check_cal();
		wb_read(reg_status, d);
		check("reg_status", d, 32'h0);
		wb_read(reg_x, d);
		check("reg_x", d, 32'h0);
		wb_read(reg_y, d);
		check("reg_y", d, 32'h0);
		wb_read(reg_z, d);
		check("reg_z", d, 32'h0);
		test_done("reset_state");

		// 2 Calibration access where upper bits of a full word drop away
		wb_write(reg_x_min, 32'hffff_f123, 4'hf);
		wb_write(reg_x_max, 32'h0000_07ab, 4'hf);
		wb_write(reg_y_min, 32'h0000_0045, 4'hf);
		wb_write(reg_y_max, 32'h0000_0654, 4'hf);
		wb_write(reg_z_thresh, 32'h0000_0321, 4'hf);
		cal_exp = '{x_min: 12'h123, x_max: 12'h7ab, y_min: 12'h045, y_max: 12'h654,
			z_thresh: 12'h321};
		check_cal();
		wb_write(reg_x_min, 32'hffff_ffcd, 4'b0001);  // Low lane only
		cal_exp.x_min = {cal_exp.x_min[11:8], 8'hcd};
		check_cal();
		wb_write(4'd9, 32'hdead_beef, 4'hf);
		wb_read(4'd9, d);
		check("reg 9", d, 32'h0);
		wb_read(4'd15, d);
		check("reg 15", d, 32'h0);
		write_cal(default_cal);
		check_cal();
		test_done("calibration_access");

		// 3 Coordinates inside the windows
		check_frame(12'h300, 12'h250, 12'h040, fc);
		test_done("coordinates");

		// 4 Clamping with default then narrower windows
		check_frame(12'h010, 12'hf80, 12'h040, fc);
		write_cal('{x_min: 12'h200, x_max: 12'h600, y_min: 12'h100, y_max: 12'h300,
			z_thresh: 12'h100});
		check_frame(12'hf00, 12'h020, 12'h040, fc);
		check_frame(12'h450, 12'h180, 12'h040, fc);
		test_done("clamping");

		// 5 Pressure where a value equal to the threshold counts as released
		write_cal(default_cal);
		check_frame(12'h300, 12'h300, 12'h3a0, fc);
		check_frame(12'h300, 12'h300, default_cal.z_thresh, fc);
		test_done("pressure");

		// 6 Random frames
		prev = fc;
		for (int i = 0; i < 4; i++) begin
			draw(rx);
			draw(ry);
			draw(rz);
			check_frame(rx, ry, rz, fc);
			check("frame count step", 32'(16'(fc - prev)), 32'd2);  // One count per frame
			prev = fc;
		end
		check("model command errors", panel.cmd_errs, 0);
		test_done("random_frames");

		end_run();
	end

endmodule

//--- sources.f
touch_pkg.sv
wb_pkg.sv
touch_spi_engine.sv
coord_scaler.sv
press_detector.sv
touch_wb_regs.sv
touch_subsystem.sv
touch_panel_model.sv
tb_touch_subsystem.sv
